// ==== hw/psrPkg.sv ====
`default_nettype none

package psrPkg;

  // Processor mode codes as held in CPSR[4:0]
  typedef enum logic [4:0] {
    ModeUsr = 5'b10000,
    ModeFiq = 5'b10001,
    ModeIrq = 5'b10010,
    ModeSvc = 5'b10011,
    ModeAbt = 5'b10111,
    ModeUnd = 5'b11011,
    ModeSys = 5'b11111
  } cpuModeT;

  // Bit positions on the exception request bus
  typedef enum logic [2:0] {
    ExcFiq         = 3'd0,
    ExcIrq         = 3'd1,
    ExcDataAbt     = 3'd2,
    ExcPrefetchAbt = 3'd3,
    ExcSwi         = 3'd4,
    ExcUndef       = 3'd5
  } excBitT;

  localparam int PsrFlagHi  = 31; // N Z C V
  localparam int PsrFlagLo  = 28;
  localparam int PsrEndian  = 9;
  localparam int PsrIrqMask = 7;
  localparam int PsrFiqMask = 6;
  localparam int PsrThumb   = 5;
  localparam int PsrModeHi  = 4;
  localparam int PsrModeLo  = 0;

  // One-hot vector select toward fetch
  localparam logic [6:0] VecReset    = 7'b000_0001;
  localparam logic [6:0] VecUndef    = 7'b000_0010;
  localparam logic [6:0] VecSwi      = 7'b000_0100;
  localparam logic [6:0] VecPrefetch = 7'b000_1000;
  localparam logic [6:0] VecDataAbt  = 7'b001_0000;
  localparam logic [6:0] VecIrq      = 7'b010_0000;
  localparam logic [6:0] VecFiq      = 7'b100_0000;
  localparam logic [6:0] VecNone     = 7'b000_0000;

  // SVC mode with I and F set before the bank adds E
  localparam logic [31:0] ResetPsr = 32'h0000_00D3;

  function automatic logic modeIsLegal(input logic [4:0] mode);
    case (mode)
      ModeUsr, ModeFiq, ModeIrq, ModeSvc, ModeAbt, ModeUnd, ModeSys: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Only the five exception modes own a saved register
  function automatic logic modeHasSpsr(input logic [4:0] mode);
    case (mode)
      ModeFiq, ModeIrq, ModeSvc, ModeAbt, ModeUnd: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== hw/excIf.sv ====
`timescale 1ns/1ns
`default_nettype none

// Exception command path, prioritizer to bank
interface excIf import psrPkg::*; ();

  cpuModeT curMode;    // From CPSR, may carry an illegal code
  logic    irqMasked;  // CPSR I bit
  logic    fiqMasked;  // CPSR F bit

  logic    take;       // One-cycle command, always accepted
  cpuModeT targetMode;
  logic    setFiqMask; // FIQ entry only

  modport prio (
    input  curMode, irqMasked, fiqMasked,
    output take, targetMode, setFiqMask
  );

  modport bank (
    output curMode, irqMasked, fiqMasked,
    input  take, targetMode, setFiqMask
  );

endinterface

`default_nettype wire

// ==== hw/msrIf.sv ====
`timescale 1ns/1ns
`default_nettype none

// MSR write path between the merge logic and the bank
interface msrIf ();

  logic [31:0] cpsr;      // Current status
  logic [31:0] spsrCur;   // Saved status of current mode

  // Never both high in one cycle
  logic        writeCpsr;
  logic        writeSpsr;
  logic [31:0] writeData; // Already merged by field mask

  modport writer (
    input  cpsr, spsrCur,
    output writeCpsr, writeSpsr, writeData
  );

  modport bank (
    output cpsr, spsrCur,
    input  writeCpsr, writeSpsr, writeData
  );

endinterface

`default_nettype wire

// ==== hw/exceptionPriority.sv ====
`timescale 1ns/1ns
`default_nettype none

module exceptionPriority import psrPkg::*; (
  input  logic       reset,
  input  logic [5:0] exceptions,
  excIf.prio         exc,
  output logic [6:0] pcVectorAddressE
);

  logic [5:0] liveReq;  // Requests after I/F masking
  logic       winValid;
  cpuModeT    winMode;
  logic [6:0] winVec;
  logic       winFiq;

  always_comb begin
    liveReq = exceptions;
    liveReq[ExcIrq] = exceptions[ExcIrq] & ~exc.irqMasked; // I bit blocks IRQ
    liveReq[ExcFiq] = exceptions[ExcFiq] & ~exc.fiqMasked; // F bit blocks FIQ
  end

  // Fixed priority, highest first
  always_comb begin
    winValid = 1'b1;
    winFiq   = 1'b0;
    if (liveReq[ExcDataAbt]) begin
      winMode = ModeAbt;
      winVec  = VecDataAbt;
    end else if (liveReq[ExcFiq]) begin
      winMode = ModeFiq;
      winVec  = VecFiq;
      winFiq  = 1'b1; // Only FIQ entry masks further FIQs
    end else if (liveReq[ExcIrq]) begin
      winMode = ModeIrq;
      winVec  = VecIrq;
    end else if (liveReq[ExcPrefetchAbt]) begin
      winMode = ModeAbt; // Shares abort mode with data abort
      winVec  = VecPrefetch;
    end else if (liveReq[ExcUndef]) begin
      winMode = ModeUnd;
      winVec  = VecUndef;
    end else if (liveReq[ExcSwi]) begin
      winMode = ModeSvc;
      winVec  = VecSwi;
    end else begin
      winValid = 1'b0;
      winMode  = exc.curMode; // Nothing pending
      winVec   = VecNone;
    end
  end

  // Reentry guard
  // Winner already in its own mode is dropped, no fallback to a lower request
  assign exc.take       = ~reset & winValid & (winMode != exc.curMode);
  assign exc.targetMode = winMode;
  assign exc.setFiqMask = winFiq;

  always_comb begin
    if (reset)
      pcVectorAddressE = VecReset;
    else if (exc.take)
      pcVectorAddressE = winVec;
    else
      pcVectorAddressE = VecNone; // No redirect this cycle
  end

endmodule

`default_nettype wire

// ==== hw/msrWrite.sv ====
`timescale 1ns/1ns
`default_nettype none

module msrWrite import psrPkg::*; (
  input  logic [31:0] aluOut,
  input  logic [4:0]  msrMask, // [4] SPSR select, [3:0] f s x c
  msrIf.writer        msr
);

  logic        privileged;
  logic        curHasSpsr;
  logic        toSpsr;
  logic [3:0]  byteEn;   // After privilege filtering
  logic        anyByte;
  logic [31:0] mergeBase;
  logic [31:0] merged;

  assign privileged = msr.cpsr[PsrModeHi:PsrModeLo] != ModeUsr;
  assign curHasSpsr = modeHasSpsr(msr.cpsr[PsrModeHi:PsrModeLo]);
  assign toSpsr     = msrMask[4];

  // User code may touch the flags byte and nothing else
  always_comb begin
    if (privileged)
      byteEn = msrMask[3:0];
    else
      byteEn = {msrMask[3], 3'b000};
  end

  assign anyByte   = |byteEn;
  assign mergeBase = toSpsr ? msr.spsrCur : msr.cpsr;

  // Byte-wise merge of ALU result over the selected register
  always_comb begin
    merged = mergeBase;
    for (int b = 0; b < 4; b++) begin
      if (byteEn[b])
        merged[8*b +: 8] = aluOut[8*b +: 8];
    end
    // Bad mode code leaves the old mode, I F T still land
    if (byteEn[0] && !modeIsLegal(aluOut[PsrModeHi:PsrModeLo]))
      merged[PsrModeHi:PsrModeLo] = mergeBase[PsrModeHi:PsrModeLo];
  end

  assign msr.writeData = merged;
  assign msr.writeCpsr = anyByte & ~toSpsr;
  assign msr.writeSpsr = anyByte & toSpsr & curHasSpsr; // USR and SYS have no SPSR

endmodule

`default_nettype wire

// ==== hw/psrBank.sv ====
`timescale 1ns/1ns
`default_nettype none

module psrBank import psrPkg::*; #(
  parameter logic ResetBigEndian = 1'b1
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  flagsNext,
  input  logic        restoreCpsr,
  input  logic        notStallW,
  excIf.bank          exc,
  msrIf.bank          msr,
  output logic [31:0] cpsrData,
  output logic [31:0] spsrData
);

  localparam int NumSpsr = 5;

  // Reset value with endianness folded in
  localparam logic [31:0] ResetCpsr = ResetPsr | (32'(ResetBigEndian) << PsrEndian);

  logic [31:0] cpsr;
  logic [31:0] spsr [NumSpsr]; // SVC ABT UND IRQ FIQ

  logic [2:0]  curIdx;
  logic [2:0]  tgtIdx;
  logic        curHasSpsr;
  logic        newFiqMask;
  logic [31:0] excCpsr;        // CPSR after exception entry

  // Slot of each exception mode in the saved bank
  function automatic logic [2:0] spsrSlot(input logic [4:0] mode);
    case (mode)
      ModeSvc: return 3'd0;
      ModeAbt: return 3'd1;
      ModeUnd: return 3'd2;
      ModeIrq: return 3'd3;
      ModeFiq: return 3'd4;
      default: return 3'd0; // Unused, guarded by curHasSpsr
    endcase
  endfunction

  assign curIdx     = spsrSlot(cpsr[PsrModeHi:PsrModeLo]);
  assign tgtIdx     = spsrSlot(exc.targetMode);
  assign curHasSpsr = modeHasSpsr(cpsr[PsrModeHi:PsrModeLo]);
  assign newFiqMask = exc.setFiqMask | cpsr[PsrFiqMask];

  // Flags and E survive, I set, T cleared, other bits cleared
  always_comb begin
    excCpsr                        = '0;
    excCpsr[PsrFlagHi:PsrFlagLo]   = cpsr[PsrFlagHi:PsrFlagLo];
    excCpsr[PsrEndian]             = cpsr[PsrEndian];
    excCpsr[PsrIrqMask]            = 1'b1;
    excCpsr[PsrFiqMask]            = newFiqMask;
    excCpsr[PsrThumb]              = 1'b0; // Back to ARM state
    excCpsr[PsrModeHi:PsrModeLo]   = exc.targetMode;
  end

  // Writeback half-cycle, one update per edge in priority order
  always_ff @(negedge clk) begin
    if (reset) begin
      cpsr <= ResetCpsr;
      spsr <= '{default: '0};
    end else if (exc.take) begin
      spsr[tgtIdx] <= cpsr; // Save old status for the return
      cpsr         <= excCpsr;
    end else if (msr.writeCpsr) begin
      cpsr <= msr.writeData;
    end else if (msr.writeSpsr) begin
      spsr[curIdx] <= msr.writeData;
    end else if (restoreCpsr && curHasSpsr) begin
      cpsr <= spsr[curIdx]; // Exception return
    end else if (notStallW) begin
      cpsr[PsrFlagHi:PsrFlagLo] <= flagsNext;
    end
  end

  assign cpsrData = cpsr;

  // USR, SYS and bad modes fall back to CPSR
  always_comb begin
    if (curHasSpsr)
      spsrData = spsr[curIdx];
    else
      spsrData = cpsr;
  end

  assign msr.cpsr    = cpsr;
  assign msr.spsrCur = spsr[curIdx];

  assign exc.curMode   = cpuModeT'(cpsr[PsrModeHi:PsrModeLo]);
  assign exc.irqMasked = cpsr[PsrIrqMask];
  assign exc.fiqMasked = cpsr[PsrFiqMask];

endmodule

`default_nettype wire

// ==== hw/psrControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module psrControl #(
  parameter logic ResetBigEndian = 1'b1 // E bit after reset
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  flagsNext,
  input  logic [31:0] aluOut,
  input  logic [4:0]  msrMask,     // [4] SPSR select
  input  logic [5:0]  exceptions,  // Laid out as excBitT
  input  logic        restoreCpsr,
  input  logic        notStallW,
  output logic [31:0] cpsrData,
  output logic [31:0] spsrData,
  output logic [6:0]  pcVectorAddressE
);

  excIf excLink ();
  msrIf msrLink ();

  exceptionPriority i_exceptionPriority (
    .reset            (reset),
    .exceptions       (exceptions),
    .exc              (excLink.prio),
    .pcVectorAddressE (pcVectorAddressE)
  );

  msrWrite i_msrWrite (
    .aluOut  (aluOut),
    .msrMask (msrMask),
    .msr     (msrLink.writer)
  );

  psrBank #(
    .ResetBigEndian (ResetBigEndian)
  ) i_psrBank (
    .clk         (clk),
    .reset       (reset),
    .flagsNext   (flagsNext),
    .restoreCpsr (restoreCpsr),
    .notStallW   (notStallW),
    .exc         (excLink.bank),
    .msr         (msrLink.bank),
    .cpsrData    (cpsrData),
    .spsrData    (spsrData)
  );

endmodule

`default_nettype wire

// ==== include/psrRefModel.svh ====
`ifndef PSR_REF_MODEL_SVH
`define PSR_REF_MODEL_SVH

localparam logic RefBigEndian = 1'b1; // Matches the DUT default

logic [31:0] refCpsr;
logic [31:0] refSpsr [5]; // SVC ABT UND IRQ FIQ

// Bank slot of a mode or -1 for a mode without SPSR
function automatic int savedSlot(input logic [4:0] mode);
  case (mode)
    psrPkg::ModeSvc: return 0;
    psrPkg::ModeAbt: return 1;
    psrPkg::ModeUnd: return 2;
    psrPkg::ModeIrq: return 3;
    psrPkg::ModeFiq: return 4;
    default: return -1;
  endcase
endfunction

// Only the seven architected mode codes are legal
function automatic logic legalMode(input logic [4:0] mode);
  return savedSlot(mode) >= 0 || mode == psrPkg::ModeUsr || mode == psrPkg::ModeSys;
endfunction

// Winning vector for a status word or VecNone when masked out or guarded
function automatic logic [6:0] pickWinner(input logic [5:0] req, input logic [31:0] psr,
                                          output logic [4:0] mode);
  logic [5:0] e;
  logic [6:0] vec;
  e = req & ~{4'b0, psr[psrPkg::PsrIrqMask], psr[psrPkg::PsrFiqMask]};
  if (e[2]) vec = psrPkg::VecDataAbt;
  else if (e[0]) vec = psrPkg::VecFiq;
  else if (e[1]) vec = psrPkg::VecIrq;
  else if (e[3]) vec = psrPkg::VecPrefetch;
  else if (e[5]) vec = psrPkg::VecUndef;
  else if (e[4]) vec = psrPkg::VecSwi;
  else vec = psrPkg::VecNone;
  case (vec)
    psrPkg::VecDataAbt, psrPkg::VecPrefetch: mode = psrPkg::ModeAbt;
    psrPkg::VecFiq:   mode = psrPkg::ModeFiq;
    psrPkg::VecIrq:   mode = psrPkg::ModeIrq;
    psrPkg::VecUndef: mode = psrPkg::ModeUnd;
    psrPkg::VecSwi:   mode = psrPkg::ModeSvc;
    default:          mode = psr[4:0];
  endcase
  return (mode == psr[4:0]) ? psrPkg::VecNone : vec; // Reentry guard
endfunction

function automatic logic [6:0] psrRefVector(input logic rst, input logic [5:0] req);
  logic [4:0] mode;
  return rst ? psrPkg::VecReset : pickWinner(req, refCpsr, mode);
endfunction

// Expected spsrData for the mirrored state
function automatic logic [31:0] expectedSpsr();
  int cur;
  cur = savedSlot(refCpsr[4:0]);
  return (cur >= 0) ? refSpsr[cur] : refCpsr;
endfunction

// One falling edge of the status unit
function automatic void psrRefNext(input logic rst, input logic [3:0] flags,
                                   input logic [31:0] alu, input logic [4:0] mask,
                                   input logic [5:0] req, input logic restore,
                                   input logic notStall);
  logic [4:0]  mode;
  logic [31:0] base;
  logic [31:0] val;
  logic [3:0]  en;
  int          cur;
  cur  = savedSlot(refCpsr[4:0]);
  en   = (refCpsr[4:0] == psrPkg::ModeUsr) ? {mask[3], 3'b000} : mask[3:0];
  base = (mask[4] && cur >= 0) ? refSpsr[cur] : refCpsr;
  for (int b = 0; b < 4; b++)
    val[8*b +: 8] = en[b] ? alu[8*b +: 8] : base[8*b +: 8];
  if (en[0] && !legalMode(alu[4:0]))
    val[4:0] = base[4:0];
  if (rst) begin
    refCpsr = {22'b0, RefBigEndian, 1'b0, 1'b1, 1'b1, 1'b0, psrPkg::ModeSvc}; // E I F in SVC
    refSpsr = '{default: '0};
  end else if (pickWinner(req, refCpsr, mode) != psrPkg::VecNone) begin
    refSpsr[savedSlot(mode)] = refCpsr;
    refCpsr = {refCpsr[31:28], 18'b0, refCpsr[9], 1'b0, 1'b1,
               refCpsr[6] | (mode == psrPkg::ModeFiq), 1'b0, mode};
  end else if (en != 4'b0 && !mask[4]) refCpsr = val;
  else if (en != 4'b0 && mask[4] && cur >= 0) refSpsr[cur] = val;
  else if (restore && cur >= 0) refCpsr = refSpsr[cur];
  else if (notStall) refCpsr[31:28] = flags;
endfunction

`endif

// ==== dv/psrControlTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module psrControlTb import psrPkg::*; ();

  localparam int ResetCycles    = 5;
  localparam int DirectedCycles = 50;
  localparam int RandomCycles   = 300;
  localparam int TotalCycles    = ResetCycles + DirectedCycles + RandomCycles;

  logic        clk = 1'b0;
  logic        reset;
  logic [3:0]  flagsNext;
  logic [31:0] aluOut;
  logic [4:0]  msrMask;
  logic [5:0]  exceptions;
  logic        restoreCpsr;
  logic        notStallW;
  logic [31:0] cpsrData;
  logic [31:0] spsrData;
  logic [6:0]  pcVectorAddressE;

  // Inputs as seen just before the falling edge
  logic        sReset;
  logic [3:0]  sFlags;
  logic [31:0] sAlu;
  logic [4:0]  sMask;
  logic [5:0]  sExc;
  logic        sRestore;
  logic        sNotStall;

  int     checkCount = 0;
  int     errorCount = 0;
  int     testStartErrors = 0;
  integer seed = 32'ha1f2_07a3;

  `include "psrRefModel.svh"

  psrControl #(
    .ResetBigEndian (1'b1)
  ) i_psrControl (
    .clk              (clk),
    .reset            (reset),
    .flagsNext        (flagsNext),
    .aluOut           (aluOut),
    .msrMask          (msrMask),
    .exceptions       (exceptions),
    .restoreCpsr      (restoreCpsr),
    .notStallW        (notStallW),
    .cpsrData         (cpsrData),
    .spsrData         (spsrData),
    .pcVectorAddressE (pcVectorAddressE)
  );

  always #5 clk = ~clk; // 10 ns period

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("FAIL %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One command per cycle launched on the rising edge
  task automatic driveCycle(input logic [3:0] flags, input logic [31:0] alu,
                            input logic [4:0] mask, input logic [5:0] exc,
                            input logic restore, input logic notStall);
    @(posedge clk);
    flagsNext   <= flags;
    aluOut      <= alu;
    msrMask     <= mask;
    exceptions  <= exc;
    restoreCpsr <= restore;
    notStallW   <= notStall;
  endtask

  task automatic quietCycle();
    driveCycle(4'h0, 32'h0, 5'h0, 6'h0, 1'b0, 1'b0); // Stalled so flags hold
  endtask

  task automatic expectVector(input logic [6:0] exp);
    #1;
    checkValue("pcVectorAddressE", pcVectorAddressE, exp);
  endtask

  task automatic finishTest(input string name);
    $display("Test %s finished, %0d errors", name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  // Vector checked 1 ns before the edge, state 1 ns after it
  always @(posedge clk) begin : compareOutputs
    #4;
    sReset    = reset;
    sFlags    = flagsNext;
    sAlu      = aluOut;
    sMask     = msrMask;
    sExc      = exceptions;
    sRestore  = restoreCpsr;
    sNotStall = notStallW;
    checkValue("pcVectorAddressE", pcVectorAddressE, psrRefVector(sReset, sExc));
    @(negedge clk);
    psrRefNext(sReset, sFlags, sAlu, sMask, sExc, sRestore, sNotStall);
    #1;
    checkValue("cpsrData", cpsrData, refCpsr);
    checkValue("spsrData", spsrData, expectedSpsr());
  end

  initial begin : watchdog
    #(TotalCycles * 10 * 2);
    $display("Simulation timed out before all tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : stimulus
    reset       = 1'b1;
    flagsNext   = 4'h0;
    aluOut      = 32'h0;
    msrMask     = 5'h0;
    exceptions  = 6'h0;
    restoreCpsr = 1'b0;
    notStallW   = 1'b0;

    // Reset leaves SVC with I F E set
    repeat (ResetCycles) @(posedge clk);
    checkValue("reset vector", pcVectorAddressE, VecReset);
    @(posedge clk);
    reset <= 1'b0;
    quietCycle();
    checkValue("reset cpsr", cpsrData, 32'h0000_02D3);
    checkValue("reset spsr", spsrData, 32'h0);
    finishTest("reset");

    // Data abort wins over all other requests
    driveCycle(4'h0, 32'h0, 5'h0, 6'b111111, 1'b0, 1'b0);
    expectVector(VecDataAbt);
    quietCycle();
    checkValue("abort entry cpsr", cpsrData, 32'h0000_02D7);
    checkValue("abort entry spsr", spsrData, 32'h0000_02D3);
    driveCycle(4'h0, 32'h0, 5'h0, 6'b101100, 1'b0, 1'b0); // Guarded without promotion
    expectVector(VecNone);
    quietCycle();
    checkValue("reentry cpsr", cpsrData, 32'h0000_02D7);
    finishTest("priority");

    // IRQ masked by I so undef takes over
    driveCycle(4'h0, 32'h0, 5'h0, 6'b100010, 1'b0, 1'b0);
    expectVector(VecUndef);
    quietCycle();
    checkValue("undef cpsr", cpsrData, 32'h0000_02DB);
    checkValue("undef spsr", spsrData, 32'h0000_02D7);
    driveCycle(4'h0, 32'h0000_001B, 5'b00001, 6'h0, 1'b0, 1'b0); // Clear I and F
    driveCycle(4'h0, 32'h0, 5'h0, 6'b000011, 1'b0, 1'b0);
    expectVector(VecFiq);
    quietCycle();
    checkValue("fiq cpsr", cpsrData, 32'h0000_02D1);
    checkValue("fiq spsr", spsrData, 32'h0000_021B);
    driveCycle(4'h0, 32'h0000_0051, 5'b00001, 6'h0, 1'b0, 1'b0); // I clear, F kept
    driveCycle(4'h0, 32'h0, 5'h0, 6'b000011, 1'b0, 1'b0);
    expectVector(VecIrq);
    quietCycle();
    checkValue("irq cpsr", cpsrData, 32'h0000_02D2);
    checkValue("irq spsr", spsrData, 32'h0000_0251);
    finishTest("masking");

    // Illegal mode code still writes I and F
    driveCycle(4'h0, 32'h0000_0005, 5'b00001, 6'h0, 1'b0, 1'b0);
    quietCycle();
    checkValue("illegal mode cpsr", cpsrData, 32'h0000_0212);
    driveCycle(4'h0, 32'h0000_0010, 5'b00001, 6'h0, 1'b0, 1'b0); // To user
    driveCycle(4'h0, 32'hF000_00DF, 5'b01111, 6'h0, 1'b0, 1'b0);
    quietCycle();
    checkValue("user msr cpsr", cpsrData, 32'hF000_0210);
    checkValue("user spsr", spsrData, 32'hF000_0210);
    driveCycle(4'h0, 32'h0, 5'h0, 6'b010000, 1'b0, 1'b0); // SWI back to SVC
    expectVector(VecSwi);
    quietCycle();
    checkValue("swi cpsr", cpsrData, 32'hF000_0293);
    checkValue("swi spsr", spsrData, 32'hF000_0210);
    finishTest("msr cpsr");

    driveCycle(4'h0, 32'h6000_0010, 5'b11001, 6'h0, 1'b0, 1'b0);
    quietCycle();
    checkValue("svc spsr write", spsrData, 32'h6000_0210);
    checkValue("svc cpsr kept", cpsrData, 32'hF000_0293);
    driveCycle(4'h0, 32'h0000_001F, 5'b00001, 6'h0, 1'b0, 1'b0); // To system
    driveCycle(4'h0, 32'h3000_0000, 5'b11000, 6'h0, 1'b1, 1'b0); // No SPSR here
    quietCycle();
    checkValue("sys cpsr", cpsrData, 32'hF000_021F);
    checkValue("sys spsr", spsrData, 32'hF000_021F);
    driveCycle(4'h0, 32'h0000_00D3, 5'b00001, 6'h0, 1'b0, 1'b0);
    driveCycle(4'h0, 32'hA000_0000, 5'b01000, 6'h0, 1'b1, 1'b0); // MSR beats restore
    quietCycle();
    checkValue("msr over restore", cpsrData, 32'hA000_02D3);
    checkValue("svc spsr kept", spsrData, 32'h6000_0210);
    driveCycle(4'h0, 32'h0, 5'h0, 6'h0, 1'b1, 1'b0);
    quietCycle();
    checkValue("restore cpsr", cpsrData, 32'h6000_0210);
    finishTest("msr spsr and restore");

    driveCycle(4'h5, 32'h0, 5'h0, 6'h0, 1'b0, 1'b0); // Stalled
    quietCycle();
    checkValue("stalled flags", cpsrData[31:28], 4'h6);
    driveCycle(4'h5, 32'h0, 5'h0, 6'h0, 1'b0, 1'b1);
    quietCycle();
    checkValue("writeback flags", cpsrData[31:28], 4'h5);
    driveCycle(4'h9, 32'h3000_0000, 5'b01000, 6'h0, 1'b0, 1'b1);
    quietCycle();
    checkValue("msr over flags", cpsrData[31:28], 4'h3);
    driveCycle(4'hC, 32'h0, 5'h0, 6'h0, 1'b1, 1'b1); // Restore ignored in user
    quietCycle();
    checkValue("user restore flags", cpsrData, 32'hC000_0210);

    // Random phase with rare resets and sparse requests
    for (int i = 0; i < RandomCycles; i++) begin
      @(posedge clk);
      reset       <= ($random(seed) & 31) == 0;
      flagsNext   <= $random(seed);
      aluOut      <= $random(seed);
      msrMask     <= $random(seed);
      exceptions  <= $random(seed) & $random(seed);
      restoreCpsr <= $random(seed);
      notStallW   <= $random(seed);
    end
    @(posedge clk);
    reset <= 1'b0;
    quietCycle();
    finishTest("flags, stall and random");

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== psrControl.f ====
+incdir+include
hw/psrPkg.sv
hw/excIf.sv
hw/msrIf.sv
hw/exceptionPriority.sv
hw/msrWrite.sv
hw/psrBank.sv
hw/psrControl.sv
dv/psrControlTb.sv
